// File: verilog/icache_params.svh
//--------------------
// geometry of the two-way instruction cache.
// include in every file that sizes a port or an array.
//--------------------
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

`define ICACHE_ADDR_W    32 // fetch address.
`define ICACHE_INST_W    32
`define ICACHE_LINE_W    64 // two instructions per line.

// address split is tag[31:9], index[8:3], offset[2:0].
// bit 2 picks the word within the line.
`define ICACHE_OFFSET_W  3
`define ICACHE_INDEX_W   6
`define ICACHE_SETS      64
`define ICACHE_TAG_W     23

`define ICACHE_WAYS      2  // 4 also works.
`define ICACHE_AGE_W     3  // saturates at 7.

`endif

// File: verilog/icache_pkg.sv
//--------------------
// shared types of the instruction cache.
// import with a wildcard in the module header.
//--------------------
`default_nettype none
`include "icache_params.svh"

package icache_pkg;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        CHECK,
        REFILL
    } ctrl_state_e;

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic [`ICACHE_INST_W-1:0]  inst_t;
    typedef logic [`ICACHE_AGE_W-1:0]   age_t;

endpackage

`default_nettype wire

// File: verilog/icache_way.sv
//--------------------
// one way of the cache: tag, valid, data and age per set.
// the set at index_i is registered every cycle, so hit_o
// follows one cycle after the index is presented.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_way
    import icache_pkg::*;
(
    input  wire    clk,
    input  wire    arst_n_i,
    input  index_t index_i,
    input  tag_t   tag_i,
    input  line_t  line_i,
    input  wire    wr_i,
    input  wire    touch_i,
    input  wire    age_tick_i,
    input  wire    inval_en_i,
    input  index_t inval_index_i,
    output logic   hit_o,
    output logic   valid_o,
    output line_t  line_o,
    output age_t   age_o
);

    tag_t  tag_mem   [`ICACHE_SETS];
    line_t line_mem  [`ICACHE_SETS];
    logic  valid_mem [`ICACHE_SETS];
    age_t  age_mem   [`ICACHE_SETS];

    tag_t  tag_rd;
    logic  valid_rd;

    // payload arrays.
    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_mem[index_i]  <= tag_i;
            line_mem[index_i] <= line_i;
        end
        tag_rd <= tag_mem[index_i];
        line_o <= line_mem[index_i];
    end

    // valid and age state, cleared by reset and by the fence walk.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_mem[s] <= 1'b0;
                age_mem[s]   <= '0;
            end
            valid_rd <= 1'b0;
            age_o    <= '0;
        end else begin
            if (age_tick_i) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    if (age_mem[s] != '1)
                        age_mem[s] <= age_mem[s] + 1'b1;
                end
            end
            if (touch_i)
                age_mem[index_i] <= '0; // touch beats the tick.
            if (wr_i)
                valid_mem[index_i] <= 1'b1;
            if (inval_en_i) begin
                valid_mem[inval_index_i] <= 1'b0;
                age_mem[inval_index_i]   <= '0;
            end
            valid_rd <= valid_mem[index_i];
            age_o    <= age_mem[index_i];
        end
    end

    assign valid_o = valid_rd;
    assign hit_o   = valid_rd && (tag_rd == tag_i);

endmodule

`default_nettype wire

// File: verilog/icache_ctrl.sv
//--------------------
// lookup and refill FSM of the instruction cache.
// also walks the sets while fence_i is held and drives
// the per-way write, touch and age strobes.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int WAY_W = $clog2(`ICACHE_WAYS)
) (
    input  wire                        clk,
    input  wire                        arst_n_i,
    input  wire                        inst_req_i,
    input  wire  [`ICACHE_ADDR_W-1:0]  inst_addr_i,
    input  wire                        fence_i,
    input  wire                        hit_i,
    input  wire  [WAY_W-1:0]           hit_way_i,
    input  wire  [WAY_W-1:0]           victim_way_i,
    input  wire                        mem_valid_i,
    output logic                       inst_valid_o,
    output logic                       mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0]  mem_addr_o,
    output logic [`ICACHE_WAYS-1:0]    way_wr_o,
    output logic [`ICACHE_WAYS-1:0]    way_touch_o,
    output logic                       age_tick_o,
    output logic                       inval_en_o,
    output index_t                     inval_index_o
);

    ctrl_state_e               state_q;
    ctrl_state_e               state_d;
    logic [WAY_W-1:0]          victim_q;
    logic [`ICACHE_INDEX_W:0]  fence_cnt_q; // one extra bit marks the walk as done.

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (inst_req_i && !fence_i)
                    state_d = READ;
            end
            READ: begin
                state_d = CHECK;
            end
            CHECK: begin
                if (hit_i)
                    state_d = IDLE;
                else
                    state_d = REFILL;
            end
            REFILL: begin
                if (mem_valid_i)
                    state_d = READ; // look up again, now hits.
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            victim_q    <= '0;
            fence_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == CHECK && !hit_i)
                victim_q <= victim_way_i; // hold the victim for the whole refill.
            if (!fence_i)
                fence_cnt_q <= '0;
            else if (inval_en_o)
                fence_cnt_q <= fence_cnt_q + 1'b1;
        end
    end

    // one set per cycle, only while idle.
    assign inval_en_o    = (state_q == IDLE) && fence_i && !fence_cnt_q[`ICACHE_INDEX_W];
    assign inval_index_o = fence_cnt_q[`ICACHE_INDEX_W-1:0];

    assign inst_valid_o = (state_q == CHECK) && hit_i;
    assign age_tick_o   = (state_q == CHECK) && hit_i;

    assign mem_req_o  = (state_q == REFILL);
    assign mem_addr_o = {inst_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                         {`ICACHE_OFFSET_W{1'b0}}};

    always_comb begin
        way_wr_o    = '0;
        way_touch_o = '0;
        if (state_q == CHECK && hit_i)
            way_touch_o[hit_way_i] = 1'b1;
        if (state_q == REFILL && mem_valid_i) begin
            way_wr_o[victim_q]    = 1'b1;
            way_touch_o[victim_q] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_select.sv
//--------------------
// merges the way outputs: hit, hit way, victim way and
// the instruction word picked by address bit 2.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_select
    import icache_pkg::*;
#(
    parameter int WAY_W = $clog2(`ICACHE_WAYS)
) (
    input  wire  [`ICACHE_WAYS-1:0] hit_i,
    input  wire  [`ICACHE_WAYS-1:0] valid_i,
    input  line_t                   line_i [`ICACHE_WAYS],
    input  age_t                    age_i  [`ICACHE_WAYS],
    input  wire                     word_sel_i,
    output logic                    hit_o,
    output logic [WAY_W-1:0]        hit_way_o,
    output logic [WAY_W-1:0]        victim_way_o,
    output inst_t                   inst_data_o
);

    line_t sel_line;
    logic  found;
    age_t  best_age;

    assign hit_o = |hit_i;

    always_comb begin
        hit_way_o = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (hit_i[w])
                hit_way_o = WAY_W'(w); // lowest hitting way wins.
        end
    end

    assign sel_line    = line_i[hit_way_o];
    assign inst_data_o = word_sel_i ? sel_line[`ICACHE_LINE_W-1 -: `ICACHE_INST_W]
                                    : sel_line[`ICACHE_INST_W-1:0];

    // invalid way first, then the oldest; ties go to the lower way.
    always_comb begin
        found        = 1'b0;
        best_age     = '0;
        victim_way_o = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!found && !valid_i[w]) begin
                found        = 1'b1;
                victim_way_o = WAY_W'(w);
            end
        end
        if (!found) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (w == 0 || age_i[w] > best_age) begin
                    best_age     = age_i[w];
                    victim_way_o = WAY_W'(w);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
//--------------------
// top of the set-associative instruction cache.
// connects the FSM, the ways and the selector to the core
// fetch port and the line-wide memory port.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_top
    import icache_pkg::*;
(
    input  wire                       clk,
    input  wire                       arst_n_i,
    input  wire                       inst_req_i,
    input  wire  [`ICACHE_ADDR_W-1:0] inst_addr_i,
    input  wire                       fence_i,
    input  wire                       mem_valid_i,
    input  line_t                     mem_data_i,
    output inst_t                     inst_data_o,
    output logic                      inst_valid_o,
    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o
);

    localparam int WAY_W = $clog2(`ICACHE_WAYS);

    tag_t   addr_tag;
    index_t addr_index;
    logic   addr_word;

    logic                    hit;
    logic [WAY_W-1:0]        hit_way;
    logic [WAY_W-1:0]        victim_way;
    logic [`ICACHE_WAYS-1:0] way_wr;
    logic [`ICACHE_WAYS-1:0] way_touch;
    logic                    age_tick;
    logic                    inval_en;
    index_t                  inval_index;

    logic [`ICACHE_WAYS-1:0] way_hit;
    logic [`ICACHE_WAYS-1:0] way_valid;
    line_t                   way_line [`ICACHE_WAYS];
    age_t                    way_age  [`ICACHE_WAYS];

    assign addr_tag   = inst_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign addr_index = inst_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign addr_word  = inst_addr_i[`ICACHE_OFFSET_W-1]; // upper or lower word.

    icache_ctrl #(.WAY_W(WAY_W)) u_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .inst_req_i    (inst_req_i),
        .inst_addr_i   (inst_addr_i),
        .fence_i       (fence_i),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .mem_valid_i   (mem_valid_i),
        .inst_valid_o  (inst_valid_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .way_wr_o      (way_wr),
        .way_touch_o   (way_touch),
        .age_tick_o    (age_tick),
        .inval_en_o    (inval_en),
        .inval_index_o (inval_index)
    );

    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        icache_way u_way (
            .clk           (clk),
            .arst_n_i      (arst_n_i),
            .index_i       (addr_index),
            .tag_i         (addr_tag),
            .line_i        (mem_data_i),
            .wr_i          (way_wr[g]),
            .touch_i       (way_touch[g]),
            .age_tick_i    (age_tick),
            .inval_en_i    (inval_en),
            .inval_index_i (inval_index),
            .hit_o         (way_hit[g]),
            .valid_o       (way_valid[g]),
            .line_o        (way_line[g]),
            .age_o         (way_age[g])
        );
    end

    icache_select #(.WAY_W(WAY_W)) u_select (
        .hit_i        (way_hit),
        .valid_i      (way_valid),
        .line_i       (way_line),
        .age_i        (way_age),
        .word_sel_i   (addr_word),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way),
        .inst_data_o  (inst_data_o)
    );

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
//--------------------
// testbench of the instruction cache.
// runs a table of fetches and fences against a memory
// model whose instructions equal their own addresses.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import icache_pkg::*;
;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int FENCE_CYCLES  = 70;
    localparam int FETCH_TIMEOUT = 20;
    localparam int NUM_STEPS     = 18;

    typedef enum logic {OP_FETCH, OP_FENCE} op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic        exp_miss;
    } step_t;

    logic        clk;
    logic        arst_n_i;
    logic        inst_req_i;
    logic [31:0] inst_addr_i;
    logic        fence_i;
    logic        mem_valid_i;
    line_t       mem_data_i;
    inst_t       inst_data_o;
    logic        inst_valid_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;

    integer      seed = 32'h6dbd;
    int          mem_req_count = 0;
    logic [31:0] cur_addr = '0;
    step_t       step_tab [NUM_STEPS];

    icache_top u_dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_req_i   (inst_req_i),
        .inst_addr_i  (inst_addr_i),
        .fence_i      (fence_i),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .inst_data_o  (inst_data_o),
        .inst_valid_o (inst_valid_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // set 5 is shared by tags 8, 16 and 24; set 0 holds 0x400.
    task automatic fill_table();
        step_tab[0]  = '{OP_FETCH, 32'h0000_0404, 1'b1};
        step_tab[1]  = '{OP_FETCH, 32'h0000_0400, 1'b0};
        step_tab[2]  = '{OP_FETCH, 32'h0000_1028, 1'b1};
        step_tab[3]  = '{OP_FETCH, 32'h0000_102c, 1'b0};
        step_tab[4]  = '{OP_FETCH, 32'h0000_2028, 1'b1}; // way 1 still invalid.
        step_tab[5]  = '{OP_FETCH, 32'h0000_3028, 1'b1}; // evicts older 0x1028.
        step_tab[6]  = '{OP_FETCH, 32'h0000_202c, 1'b0};
        step_tab[7]  = '{OP_FETCH, 32'h0000_1028, 1'b1};
        step_tab[8]  = '{OP_FETCH, 32'h0000_2028, 1'b0};
        step_tab[9]  = '{OP_FETCH, 32'h0000_3028, 1'b1};
        step_tab[10] = '{OP_FETCH, 32'h0000_1028, 1'b1}; // now way 1 is oldest.
        step_tab[11] = '{OP_FETCH, 32'h0000_102c, 1'b0};
        step_tab[12] = '{OP_FETCH, 32'h0000_302c, 1'b0};
        step_tab[13] = '{OP_FETCH, 32'h0000_2028, 1'b1};
        step_tab[14] = '{OP_FENCE, 32'h0000_0000, 1'b0};
        step_tab[15] = '{OP_FETCH, 32'h0000_302c, 1'b1};
        step_tab[16] = '{OP_FETCH, 32'h0000_0400, 1'b1};
        step_tab[17] = '{OP_FETCH, 32'h0000_0404, 1'b0};
    endtask

    task automatic check_quiet(input string phase);
        assert (!inst_valid_o) else
            fail_now($sformatf("ERR t=%0t inst_valid_o got %b exp 0 (%s)",
                               $time, inst_valid_o, phase));
        assert (!mem_req_o) else
            fail_now($sformatf("ERR t=%0t mem_req_o got %b exp 0 (%s)",
                               $time, mem_req_o, phase));
    endtask

    task automatic apply_reset();
        int n;
        arst_n_i = 1'b0;
        for (n = 0; n < RESET_CYCLES; n++) begin
            @(negedge clk);
            check_quiet("reset");
        end
        @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        for (n = 0; n < 4; n++) begin
            @(negedge clk);
            check_quiet("after reset");
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic exp_miss);
        int    req_before;
        int    cycles;
        bit    got;
        inst_t exp_data;
        req_before = mem_req_count;
        exp_data   = {addr[31:2], 2'b00};
        cur_addr   = addr;
        @(posedge clk);
        #1;
        inst_addr_i = addr;
        inst_req_i  = 1'b1;
        @(posedge clk); // request sampled in IDLE.
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < FETCH_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            got = inst_valid_o;
        end
        assert (got) else
            fail_now($sformatf("fetch of %h got no valid pulse within %0d cycles",
                               addr, FETCH_TIMEOUT));
        assert (inst_data_o == exp_data) else
            fail_now($sformatf("ERR t=%0t inst_data_o got %h exp %h",
                               $time, inst_data_o, exp_data));
        assert ((mem_req_count - req_before) == (exp_miss ? 1 : 0)) else
            fail_now($sformatf("ERR t=%0t mem_req_o requests got %0d exp %0d",
                               $time, mem_req_count - req_before, exp_miss ? 1 : 0));
        if (!exp_miss) begin
            assert (cycles == 2) else
                fail_now($sformatf("ERR t=%0t hit latency got %0d exp 2", $time, cycles));
        end
        @(posedge clk);
        #1;
        inst_req_i = 1'b0;
        @(negedge clk);
        check_quiet("after valid pulse");
    endtask

    task automatic run_fence();
        int n;
        @(posedge clk);
        #1;
        fence_i = 1'b1;
        for (n = 0; n < FENCE_CYCLES; n++) begin
            @(negedge clk);
            check_quiet("fence");
        end
        @(posedge clk);
        #1;
        fence_i = 1'b0;
    endtask

    // memory model, answers each line request after 0 to 5 cycles.
    always begin : mem_responder
        int delay;
        @(negedge clk);
        if (mem_req_o) begin
            mem_req_count++;
            assert (mem_addr_o == {cur_addr[31:3], 3'b000}) else
                fail_now($sformatf("ERR t=%0t mem_addr_o got %h exp %h",
                                   $time, mem_addr_o, {cur_addr[31:3], 3'b000}));
            delay = {$random(seed)} % 6;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            #1;
            mem_valid_i = 1'b1;
            mem_data_i  = {mem_addr_o + 32'd4, mem_addr_o};
            @(posedge clk);
            #1;
            mem_valid_i = 1'b0;
            mem_data_i  = '0;
        end
    end

    initial begin : main
        int i;
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        inst_req_i  = 1'b0;
        inst_addr_i = '0;
        fence_i     = 1'b0;
        mem_valid_i = 1'b0;
        mem_data_i  = '0;
        fill_table();
        apply_reset();
        for (i = 0; i < NUM_STEPS; i++) begin
            if (step_tab[i].op == OP_FENCE)
                run_fence();
            else
                run_fetch(step_tab[i].addr, step_tab[i].exp_miss);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_way.sv
verilog/icache_ctrl.sv
verilog/icache_select.sv
verilog/icache_top.sv
dv/icache_tb.sv

// File: run.sh
#!/bin/sh
# build the instruction cache testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module icache_tb -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
